// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_trace_unit -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	! grep -q "Regression failed" $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== flist.f ====
+incdir+sim
verilog/pipe_pkg.sv
verilog/trace_pkg.sv
verilog/pipe_stage_tracker.sv
verilog/trace_record_fifo.sv
verilog/trace_serializer.sv
verilog/trace_unit_top.sv
sim/tb_trace_unit.sv

// ==== sim/trace_model.svh ====
/*
  Trace unit reference model
  Five tracked slots, exit ordering, record FIFO with drop counting and
  the link serializer, producing the expected word stream
*/
`ifndef TRACE_MODEL_SVH
`define TRACE_MODEL_SVH

// One tracked instruction in the model
typedef struct {
  bit          v;
  logic [31:0] pc;
  logic [31:0] instr;
  int          stamp;   // Cycle of fetch
  int          ifs;
  int          ids;
} mslot_t;

// FIFO entry with the drop count taken at push
typedef struct {
  trace_pkg::trace_rec_t rec;
  logic [7:0]            drops;
} mfifo_t;

// Expected link word, idx 0 header, 1 pc, 2 instr
typedef struct {
  logic                   last;
  trace_pkg::trace_word_u w;
  int                     idx;
} mword_t;

mslot_t                m_if, m_id, m_ex, m_mem, m_wb;
trace_pkg::trace_rec_t m_pend[$];       // Exits not yet handed to the FIFO
bit                    m_rv;            // Record presented to the FIFO
trace_pkg::trace_rec_t m_rec;
mfifo_t                m_fifo[$];
logic [7:0]            m_drops;
int                    m_total_drops;
int                    m_credits;
int                    m_wsel;
int                    m_cyc;
mword_t                exp_q[$];

function automatic trace_pkg::trace_rec_t exit_record(mslot_t s, trace_pkg::exit_kind_t k);
  trace_pkg::trace_rec_t r;
  int                    lat;
  lat         = m_cyc - s.stamp;
  r.kind      = k;
  r.if_stalls = 6'(s.ifs);
  r.id_stalls = 6'(s.ids);
  r.latency   = (lat > 1023) ? 10'h3ff : 10'(lat);  // Saturates
  r.pc        = s.pc;
  r.instr     = s.instr;
  return r;
endfunction

task automatic model_reset();
  m_if.v = 0;
  m_id.v = 0;
  m_ex.v = 0;
  m_mem.v = 0;
  m_wb.v = 0;
  m_rv = 0;
  m_drops = '0;
  m_total_drops = 0;
  m_credits = LINK_CREDITS;
  m_wsel = 0;
  m_cyc = 0;
endtask

// One clock edge with the inputs held during that cycle
task automatic model_clock(input pipe_pkg::stage_evt_t e, input logic cr);
  mslot_t                 cur;
  bit                     full;
  bit                     send;
  trace_pkg::trace_word_u w;
  mword_t                 x;
  mfifo_t                 f;
  full = (m_fifo.size() == FIFO_DEPTH);                 // Before this edge's pop
  send = (m_fifo.size() != 0) && (m_credits > 0);
  if (send) begin
    w = '0;
    case (m_wsel)
      0: begin
        w.hdr.kind      = m_fifo[0].rec.kind;
        w.hdr.if_stalls = m_fifo[0].rec.if_stalls;
        w.hdr.id_stalls = m_fifo[0].rec.id_stalls;
        w.hdr.drops     = m_fifo[0].drops;
        w.hdr.latency   = m_fifo[0].rec.latency;
      end
      1:       w.raw = m_fifo[0].rec.pc;
      default: w.raw = m_fifo[0].rec.instr;
    endcase
    x.last = (m_wsel == 2);
    x.w    = w;
    x.idx  = m_wsel;
    exp_q.push_back(x);
    if (m_wsel == 2) begin
      void'(m_fifo.pop_front());
      m_wsel = 0;
    end else begin
      m_wsel++;
    end
  end
  m_credits = m_credits + int'(cr) - int'(send);
  if (m_rv) begin
    if (full) begin
      if (m_drops != 8'hff)
        m_drops++;
      m_total_drops++;
    end else begin
      f.rec   = m_rec;
      f.drops = m_drops;
      m_fifo.push_back(f);
      m_drops = '0;
    end
  end
  // Retire before squash on the same cycle
  if (m_wb.v)
    m_pend.push_back(exit_record(m_wb, trace_pkg::RETIRED));
  if (e.flush && m_id.v)
    m_pend.push_back(exit_record(m_id, trace_pkg::SQUASHED));
  m_rv = (m_pend.size() != 0);
  if (m_rv)
    m_rec = m_pend.pop_front();
  cur = m_if;
  if (e.fetch_valid) begin
    cur.v     = 1;
    cur.pc    = e.pc;
    cur.instr = e.instr;
    cur.stamp = m_cyc;
    cur.ifs   = 0;
    cur.ids   = 0;
  end
  m_wb  = m_mem;
  m_mem = m_ex;
  if (e.stall || e.flush)
    m_ex.v = 0;                                         // Bubble
  else
    m_ex = m_id;
  if (!e.stall) begin
    m_id   = cur;
    m_if.v = 0;
  end else begin
    m_if = cur;
    if (m_if.v && m_if.ifs < 63)
      m_if.ifs++;
    if (e.flush)
      m_id.v = 0;
    else if (m_id.v && m_id.ids < 63)
      m_id.ids++;
  end
  m_cyc++;
endtask

`endif

// ==== sim/tb_trace_unit.sv ====
/*
  Trace unit testbench
  Random core events and a credit sink from an LFSR, every link word
  checked against the reference model
*/
module tb_trace_unit;

  localparam int FIFO_DEPTH   = 8;
  localparam int LINK_CREDITS = 4;
  localparam int STIM_CYCLES  = 2000;
  localparam int DRAIN_CYCLES = 300;
  localparam int RUN_CYCLES   = STIM_CYCLES + DRAIN_CYCLES;
  localparam int HOLD_START   = 800;   // Sink withholds credits from here
  localparam int HOLD_END     = 1100;

  logic                   clk;
  logic                   rst_n;
  pipe_pkg::stage_evt_t   evt;
  logic                   credit_ret;
  trace_pkg::trace_link_t link;

  logic [31:0] lfsr;
  int          cyc;
  int          wd_cnt;
  int          outstanding;   // Words held by the sink
  int          link_drops;    // Drop counts reported in received headers
  int          err_value;
  int          err_proto;

  `include "trace_model.svh"

  trace_unit_top #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .LINK_CREDITS (LINK_CREDITS)
  ) i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .evt        (evt),
    .credit_ret (credit_ret),
    .link       (link)
  );

  always #2 clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], b};
      v    = {v[30:0], b};
    end
    return v;
  endfunction

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic drive_cycle();
    logic withhold;
    withhold   = (cyc >= HOLD_START) && (cyc < HOLD_END);
    evt        = '0;
    credit_ret = 1'b0;
    if (cyc < STIM_CYCLES) begin
      evt.stall = (rnd(2) == 0);                        // About one in four
      evt.flush = (rnd(3) == 0);
      if (!m_if.v && rnd(2) != 0) begin                 // Only into a free IF
        evt.fetch_valid = 1'b1;
        evt.pc          = rnd(32);
        evt.instr       = rnd(32);
      end
    end
    if (!withhold && outstanding > 0 && rnd(1) == 1) begin
      credit_ret = 1'b1;                                // Random return delay
      outstanding--;
    end
  endtask

  // Model steps on the same edge as the DUT
  always @(posedge clk) begin
    if (rst_n)
      model_clock(evt, credit_ret);
  end

  //////////////////////////////////////////////////
  // Link checker
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    mword_t x;
    if (rst_n && link.valid) begin
      outstanding++;
      if (outstanding > LINK_CREDITS) begin
        err_proto++;
        $display("Sink holds %0d words, more than the %0d credits, at time %0t",
                 outstanding, LINK_CREDITS, $time);
      end
      if (exp_q.size() == 0) begin
        err_proto++;
        $display("Word arrived on the link with no record expected at time %0t", $time);
      end else begin
        x = exp_q.pop_front();
        if (link.last !== x.last) begin
          err_value++;
          $display("FAIL %0t: last got %0b exp %0b", $time, link.last, x.last);
        end
        if (x.idx == 0) begin
          link_drops += link.word.hdr.drops;
          if (link.word.hdr.kind !== x.w.hdr.kind) begin
            err_value++;
            $display("FAIL %0t: kind got %0d exp %0d", $time,
                     link.word.hdr.kind, x.w.hdr.kind);
          end
          if (link.word.hdr.if_stalls !== x.w.hdr.if_stalls) begin
            err_value++;
            $display("FAIL %0t: if_stalls got %0d exp %0d", $time,
                     link.word.hdr.if_stalls, x.w.hdr.if_stalls);
          end
          if (link.word.hdr.id_stalls !== x.w.hdr.id_stalls) begin
            err_value++;
            $display("FAIL %0t: id_stalls got %0d exp %0d", $time,
                     link.word.hdr.id_stalls, x.w.hdr.id_stalls);
          end
          if (link.word.hdr.drops !== x.w.hdr.drops) begin
            err_value++;
            $display("FAIL %0t: drops got %0d exp %0d", $time,
                     link.word.hdr.drops, x.w.hdr.drops);
          end
          if (link.word.hdr.latency !== x.w.hdr.latency) begin
            err_value++;
            $display("FAIL %0t: latency got %0d exp %0d", $time,
                     link.word.hdr.latency, x.w.hdr.latency);
          end
        end else if (link.word.raw !== x.w.raw) begin
          err_value++;
          $display("FAIL %0t: %s word got %h exp %h", $time,
                   (x.idx == 1) ? "pc" : "instr", link.word.raw, x.w.raw);
        end
      end
    end
  end

  // Hang guard past the full run length
  always @(posedge clk) begin
    wd_cnt++;
    if (wd_cnt > RUN_CYCLES + 60) begin
      $display("Timeout: run did not reach its end");
      $display("Regression failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    evt         = '0;
    credit_ret  = 1'b0;
    lfsr        = 32'he99b_9213;
    cyc         = 0;
    wd_cnt      = 0;
    outstanding = 0;
    link_drops  = 0;
    err_value   = 0;
    err_proto   = 0;
    model_reset();
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    for (cyc = 0; cyc < RUN_CYCLES; cyc++) begin
      drive_cycle();
      @(posedge clk);
      #1;
    end
    evt        = '0;
    credit_ret = 1'b0;
    if (exp_q.size() != 0 || m_fifo.size() != 0 || m_pend.size() != 0 || m_rv) begin
      err_proto++;
      $display("Records still missing at end of run, %0d words and %0d records pending",
               exp_q.size(), m_fifo.size() + m_pend.size());
    end
    if (link_drops == 0) begin
      err_proto++;
      $display("No dropped record was reported in any header on the link");
    end
    $display("Errors: %0d wrong values, %0d protocol, %0d records dropped by design",
             err_value, err_proto, m_total_drops);
    if (err_value == 0 && err_proto == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== verilog/pipe_pkg.sv ====
/*
  Pipeline types for the trace unit
  Stage encoding of a tracked slot and the per-cycle event that the
  five-stage core presents to the tracker
*/
package pipe_pkg;

  // Stage held by a tracked instruction slot
  typedef enum logic [2:0] {
    EMPTY,      // No instruction in the slot
    FETCH,
    DECODE,
    EXECUTE,
    MEMORY,
    WRITEBACK
  } stage_t;

  // Core event presented each cycle (67 bits)
  typedef struct packed {
    logic        fetch_valid;  // New instruction in IF this cycle
    logic [31:0] pc;           // PC of the new instruction
    logic [31:0] instr;        // Instruction word
    logic        stall;        // IF and ID hold, bubble into EX
    logic        flush;        // Squash whatever sits in ID
  } stage_evt_t;

endpackage

// ==== verilog/pipe_stage_tracker.sv ====
/*
  Pipeline stage tracker
  Follows every instruction through IF, ID, EX, MEM and WB from the core's
  stall and flush events and emits one record per instruction that leaves,
  retired from WB or squashed in ID, at most one record per cycle
*/
module pipe_stage_tracker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  pipe_pkg::stage_evt_t  evt,
  output logic                  rec_valid,
  output trace_pkg::trace_rec_t rec
);

  localparam int STAMP_W    = 16;              // Wider than latency so it can saturate
  localparam int SIDE_DEPTH = 3;               // ID..WB occupancy caps the exit backlog at 3
  localparam int POOL_N     = SIDE_DEPTH + 2;  // Backlog plus retire plus squash

  // One tracked instruction
  typedef struct packed {
    pipe_pkg::stage_t   stage;      // EMPTY when unused
    logic [31:0]        pc;
    logic [31:0]        instr;
    logic [STAMP_W-1:0] stamp;      // Cycle of fetch_valid
    logic [5:0]         if_stalls;
    logic [5:0]         id_stalls;
  } slot_t;

  slot_t              if_q, id_q, ex_q, mem_q, wb_q;  // One slot per stage
  slot_t              if_cur;                          // IF content this cycle
  logic [STAMP_W-1:0] cycle_q;                         // Free-running cycle stamp

  logic                  ret_hit, sq_hit;
  trace_pkg::trace_rec_t ret_rec, sq_rec;

  trace_pkg::trace_rec_t side_q [SIDE_DEPTH];  // Exits waiting for the record port
  trace_pkg::trace_rec_t side_d [SIDE_DEPTH];
  trace_pkg::trace_rec_t pool   [POOL_N];      // Pending exits in exit order
  logic [2:0]            side_cnt_q, side_cnt_d;
  logic [2:0]            pool_cnt;
  logic                  out_hit;
  trace_pkg::trace_rec_t out_rec;

  // Advance a slot, an empty slot stays empty
  function automatic slot_t move(slot_t s, pipe_pkg::stage_t st);
    slot_t r;
    r = s;
    if (s.stage != pipe_pkg::EMPTY)
      r.stage = st;
    return r;
  endfunction

  function automatic logic [5:0] sat_inc6(logic [5:0] v);
    return (v == 6'h3f) ? v : v + 6'd1;
  endfunction

  function automatic trace_pkg::trace_rec_t make_rec(slot_t s, trace_pkg::exit_kind_t k,
                                                     logic [STAMP_W-1:0] now);
    trace_pkg::trace_rec_t r;
    logic [STAMP_W-1:0]    age;
    age         = now - s.stamp;                 // Wraps cleanly in modulo arithmetic
    r.kind      = k;
    r.if_stalls = s.if_stalls;
    r.id_stalls = s.id_stalls;
    r.latency   = (age > STAMP_W'(1023)) ? 10'h3ff : age[9:0];
    r.pc        = s.pc;
    r.instr     = s.instr;
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Slot movement
  //////////////////////////////////////////////////

  // A new fetch lands in IF on the cycle it is presented
  always_comb begin
    if_cur = if_q;
    if (evt.fetch_valid) begin
      if_cur       = '0;
      if_cur.stage = pipe_pkg::FETCH;
      if_cur.pc    = evt.pc;
      if_cur.instr = evt.instr;
      if_cur.stamp = cycle_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_q    <= '0;
      id_q    <= '0;
      ex_q    <= '0;
      mem_q   <= '0;
      wb_q    <= '0;
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      wb_q    <= move(mem_q, pipe_pkg::WRITEBACK);  // Back end never stalls
      mem_q   <= move(ex_q, pipe_pkg::MEMORY);
      if (evt.stall || evt.flush)
        ex_q <= '0;                                 // Bubble into EX
      else
        ex_q <= move(id_q, pipe_pkg::EXECUTE);
      if (!evt.stall) begin
        id_q <= move(if_cur, pipe_pkg::DECODE);
        if_q <= '0;
      end else begin
        if_q <= if_cur;                             // IF holds, charge one stall
        if (if_cur.stage != pipe_pkg::EMPTY)
          if_q.if_stalls <= sat_inc6(if_cur.if_stalls);
        if (evt.flush)
          id_q <= '0;                               // Flush wins over stall in ID
        else if (id_q.stage != pipe_pkg::EMPTY)
          id_q.id_stalls <= sat_inc6(id_q.id_stalls);
      end
    end
  end

  //////////////////////////////////////////////////
  // Exit records
  //////////////////////////////////////////////////

  assign ret_hit = (wb_q.stage != pipe_pkg::EMPTY);              // Leaves WB this cycle
  assign sq_hit  = evt.flush && (id_q.stage != pipe_pkg::EMPTY);
  assign ret_rec = make_rec(wb_q, trace_pkg::RETIRED, cycle_q);
  assign sq_rec  = make_rec(id_q, trace_pkg::SQUASHED, cycle_q);

  // Older backlog first, then retire, then squash of the same cycle
  always_comb begin
    for (int i = 0; i < POOL_N; i++)
      pool[i] = '0;
    for (int i = 0; i < SIDE_DEPTH; i++)
      pool[i] = side_q[i];
    pool_cnt = side_cnt_q;
    if (ret_hit) begin
      pool[pool_cnt] = ret_rec;
      pool_cnt       = pool_cnt + 3'd1;
    end
    if (sq_hit) begin
      pool[pool_cnt] = sq_rec;
      pool_cnt       = pool_cnt + 3'd1;
    end
    out_hit    = (pool_cnt != 3'd0);
    out_rec    = pool[0];                                        // Head of the backlog
    side_cnt_d = out_hit ? pool_cnt - 3'd1 : 3'd0;
    for (int i = 0; i < SIDE_DEPTH; i++)
      side_d[i] = pool[i+1];                                     // Shift the rest down
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      side_cnt_q <= '0;
      rec_valid  <= 1'b0;
    end else begin
      side_cnt_q <= side_cnt_d;
      rec_valid  <= out_hit;                                     // One cycle after exit
    end
  end

  always_ff @(posedge clk) begin
    rec <= out_rec;
    for (int i = 0; i < SIDE_DEPTH; i++)
      side_q[i] <= side_d[i];
  end

  // IF only stays occupied after a stall, so the core must not fetch over it
  a_no_fetch_into_held_if: assert property (@(posedge clk) disable iff (!rst_n)
    evt.fetch_valid |-> (if_q.stage == pipe_pkg::EMPTY));

  // Backlog must fit, otherwise an exit record is lost
  a_side_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    side_cnt_d <= 3'(SIDE_DEPTH));

endmodule

// ==== verilog/trace_pkg.sv ====
/*
  Trace record types
  Record built per exiting instruction, the 32-bit header layout, the
  link word read as header or raw payload, and the credit link itself
*/
package trace_pkg;

  // How the instruction left the pipeline, zero is never a valid kind
  typedef enum logic [1:0] {
    RETIRED  = 2'b01,
    SQUASHED = 2'b10
  } exit_kind_t;

  // Record from tracker to FIFO, drop count is added in the FIFO
  typedef struct packed {
    exit_kind_t  kind;
    logic [5:0]  if_stalls;  // Saturating
    logic [5:0]  id_stalls;  // Saturating
    logic [9:0]  latency;    // Fetch to exit, saturating
    logic [31:0] pc;
    logic [31:0] instr;
  } trace_rec_t;

  // First word of every record on the link
  typedef struct packed {
    exit_kind_t  kind;       // [31:30]
    logic [5:0]  if_stalls;  // [29:24]
    logic [5:0]  id_stalls;  // [23:18]
    logic [7:0]  drops;      // [17:10] records lost before this one
    logic [9:0]  latency;    // [9:0]
  } trace_hdr_t;

  // One link word, decoded as header or as pc/instr payload
  typedef union packed {
    trace_hdr_t  hdr;
    logic [31:0] raw;
  } trace_word_u;

  // Credit link toward the sink
  typedef struct packed {
    logic        valid;
    logic        last;       // Set on the instr word only
    trace_word_u word;
  } trace_link_t;

endpackage

// ==== verilog/trace_record_fifo.sv ====
/*
  Trace record FIFO
  Circular buffer of whole records with a first-word-fall-through head;
  records arriving while full are discarded and counted
*/
module trace_record_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rec_valid,
  input  trace_pkg::trace_rec_t rec,
  input  logic                  pop,
  output logic                  head_valid,
  output trace_pkg::trace_rec_t head,
  output logic [7:0]            head_drops
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // Stored entry, drops taken at push time
  typedef struct packed {
    logic [7:0]            drops;
    trace_pkg::trace_rec_t rec;
  } entry_t;

  entry_t           mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic [7:0]       drop_cnt;      // Discards since last accepted push
  logic             full;
  logic             push_ok, push_drop;

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full      = (count == CNT_W'(FIFO_DEPTH));
  assign push_ok   = rec_valid && !full;
  assign push_drop = rec_valid && full;   // Full on push, record lost

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      drop_cnt <= '0;
    end else begin
      if (push_ok)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      count <= count + CNT_W'(push_ok) - CNT_W'(pop);
      if (push_ok)
        drop_cnt <= '0;                   // Accepted record carries the old value
      else if (push_drop && (drop_cnt != 8'hff))
        drop_cnt <= drop_cnt + 8'd1;      // Saturating
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok)
      mem[wr_ptr] <= '{drops: drop_cnt, rec: rec};
  end

  // Head shows the oldest entry, valid one cycle after its push
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr].rec;
  assign head_drops = mem[rd_ptr].drops;

  // Serializer may only take a record that is present
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> head_valid);

endmodule

// ==== verilog/trace_serializer.sv ====
/*
  Trace serializer
  Sends each head record as header, pc and instr words over the credit
  link, one word per cycle and only while a credit is held
*/
module trace_serializer #(
  parameter int LINK_CREDITS = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   head_valid,
  input  trace_pkg::trace_rec_t  head,
  input  logic [7:0]             head_drops,
  output logic                   pop,
  input  logic                   credit_ret,
  output trace_pkg::trace_link_t link
);

  localparam int CRD_W = $clog2(LINK_CREDITS + 1);

  // Word of the current record to send next
  typedef enum logic [1:0] {
    W_HDR,
    W_PC,
    W_INSTR
  } wsel_t;

  wsel_t                  wsel_q;
  logic [CRD_W-1:0]       credits_q;  // Words the sink can still take
  logic                   send;
  trace_pkg::trace_word_u word;
  logic                   valid_q;
  logic                   last_q;
  trace_pkg::trace_word_u word_q;

  assign send = head_valid && (credits_q != '0);
  assign pop  = send && (wsel_q == W_INSTR);     // Record done with its last word

  //////////////////////////////////////////////////
  // Word build
  //////////////////////////////////////////////////

  always_comb begin
    word = '0;
    case (wsel_q)
      W_HDR: begin
        word.hdr.kind      = head.kind;          // Header view of the union
        word.hdr.if_stalls = head.if_stalls;
        word.hdr.id_stalls = head.id_stalls;
        word.hdr.drops     = head_drops;
        word.hdr.latency   = head.latency;
      end
      W_PC:    word.raw = head.pc;               // Raw payload view
      default: word.raw = head.instr;
    endcase
  end

  //////////////////////////////////////////////////
  // Word counter and credits
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wsel_q    <= W_HDR;
      credits_q <= CRD_W'(LINK_CREDITS);         // Full credit after reset
      valid_q   <= 1'b0;
    end else begin
      valid_q   <= send;
      credits_q <= credits_q + CRD_W'(credit_ret) - CRD_W'(send);
      if (send) begin
        case (wsel_q)
          W_HDR:   wsel_q <= W_PC;
          W_PC:    wsel_q <= W_INSTR;
          default: wsel_q <= W_HDR;
        endcase
      end
    end
  end

  // Payload holds between sends
  always_ff @(posedge clk) begin
    if (send) begin
      last_q <= (wsel_q == W_INSTR);
      word_q <= word;
    end
  end

  assign link = '{valid: valid_q, last: last_q, word: word_q};

  // Sink returns no more credits than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credits_q <= CRD_W'(LINK_CREDITS));

endmodule

// ==== verilog/trace_unit_top.sv ====
/*
  Trace unit top
  Stage tracker feeding the record FIFO, drained by the link serializer
*/
module trace_unit_top #(
  parameter int FIFO_DEPTH   = 8,  // Records
  parameter int LINK_CREDITS = 4   // Words
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  pipe_pkg::stage_evt_t   evt,
  input  logic                   credit_ret,
  output trace_pkg::trace_link_t link
);

  logic                  rec_valid;   // Tracker to FIFO, no back-pressure
  trace_pkg::trace_rec_t rec;
  logic                  head_valid;  // FIFO head to serializer
  trace_pkg::trace_rec_t head;
  logic [7:0]            head_drops;
  logic                  pop;

  pipe_stage_tracker i_tracker (
    .clk       (clk),
    .rst_n     (rst_n),
    .evt       (evt),
    .rec_valid (rec_valid),
    .rec       (rec)
  );

  trace_record_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .rec_valid  (rec_valid),
    .rec        (rec),
    .pop        (pop),
    .head_valid (head_valid),
    .head       (head),
    .head_drops (head_drops)
  );

  trace_serializer #(
    .LINK_CREDITS (LINK_CREDITS)
  ) i_ser (
    .clk        (clk),
    .rst_n      (rst_n),
    .head_valid (head_valid),
    .head       (head),
    .head_drops (head_drops),
    .pop        (pop),
    .credit_ret (credit_ret),
    .link       (link)
  );

endmodule
